/* verification/tb_rv_encode.svh */
`ifndef TB_RV_ENCODE_SVH
`define TB_RV_ENCODE_SVH

function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd,
                                            input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

// The J immediate is scattered over the word. Its bit 0 is always zero and not encoded.
function automatic logic [31:0] j_type_word(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

function automatic logic is_supported(input logic [31:0] instr);
  logic [2:0] f3;
  logic [6:0] f7;
  f3 = instr[14:12];
  f7 = instr[31:25];
  case (instr[6:0])
    OPC_LUI, OPC_AUIPC, OPC_JAL: return 1'b1;
    OPC_JALR:   return f3 == 3'b000;
    OPC_OP:     return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
    OPC_OP_IMM: return (f3 != 3'b001 && f3 != 3'b101) || f7 == 7'h00 ||
                       (f7 == 7'h20 && f3 == 3'b101);
    default:    return 1'b0;
  endcase
endfunction

function automatic logic writes_register(input logic [31:0] instr);
  return is_supported(instr) && instr[11:7] != 5'd0;
endfunction

// Result of one instruction, given the two source register values it reads.
function automatic logic [XLEN-1:0] expected_result(input logic [31:0] instr,
                                                    input logic [XLEN-1:0] pc,
                                                    input logic [XLEN-1:0] a,
                                                    input logic [XLEN-1:0] b);
  logic [XLEN-1:0] upper;
  logic [XLEN-1:0] y;
  logic [4:0]      sh;
  upper = {instr[31:12], 12'b0};
  y     = (instr[6:0] == OPC_OP) ? b : {{20{instr[31]}}, instr[31:20]};
  sh    = y[4:0];
  if (!is_supported(instr)) return '0;
  case (instr[6:0])
    OPC_LUI:           return upper;
    OPC_AUIPC:         return pc + upper;
    OPC_JAL, OPC_JALR: return pc + 32'd4;
    default: ;
  endcase
  case (instr[14:12])
    3'b000:  return (instr[6:0] == OPC_OP && instr[30]) ? a - y : a + y;
    3'b001:  return a << sh;
    3'b010:  return {31'b0, $signed(a) < $signed(y)};
    3'b011:  return {31'b0, a < y};
    3'b100:  return a ^ y;
    3'b101: begin
      if (instr[30]) return $signed(a) >>> sh;
      return a >> sh;
    end
    3'b110:  return a | y;
    default: return a & y;
  endcase
endfunction

`endif

/* verification/tb_rv_exec.sv */
`default_nettype none

module tb_rv_exec
  import core_pkg::*;
  import isa_pkg::*;
();

  logic                  clk;
  logic                  reset_i;
  logic                  instr_valid_i;
  logic [XLEN-1:0]       instr_i;
  logic [XLEN-1:0]       pc_i;
  logic                  rd_we_o;
  logic [REG_ADDR_W-1:0] rd_addr_o;
  logic [XLEN-1:0]       rd_data_o;

  // Reference registers and the expectation for the cycle just issued
  // (_q is the one being checked).
  logic [XLEN-1:0]       ref_regs [NUM_REGS];
  logic                  chk_en;
  logic                  chk_q;
  logic                  exp_we;
  logic                  exp_we_q;
  logic [REG_ADDR_W-1:0] exp_addr;
  logic [REG_ADDR_W-1:0] exp_addr_q;
  logic [XLEN-1:0]       exp_data;
  logic [XLEN-1:0]       exp_data_q;
  logic [31:0]           lfsr_state;
  int                    errors;
  int                    issued;
  int                    seen;
  int                    tests_run;
  int                    tests_failed;

  `include "tb_rv_encode.svh"

  rv_exec_top dut (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rd_we_o       (rd_we_o),
    .rd_addr_o     (rd_addr_o),
    .rd_data_o     (rd_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset_i) begin
      seen <= 0;
    end else if (chk_q) begin
      seen <= seen + 1;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  a_we_matches : assert property (@(posedge clk) disable iff (reset_i)
      chk_q |-> rd_we_o == exp_we_q)
    else begin
      $display("ERROR at time %0t: rd_we_o is %0b, expected %0b", $time,
               $sampled(rd_we_o), exp_we_q);
      errors++;
    end

  a_addr_matches : assert property (@(posedge clk) disable iff (reset_i)
      chk_q && exp_we_q |-> rd_addr_o == exp_addr_q)
    else begin
      $display("ERROR at time %0t: rd_addr_o is %0d, expected %0d", $time,
               $sampled(rd_addr_o), exp_addr_q);
      errors++;
    end

  a_data_matches : assert property (@(posedge clk) disable iff (reset_i)
      chk_q |-> rd_data_o == exp_data_q)
    else begin
      $display("ERROR at time %0t: rd_data_o is %h, expected %h", $time,
               $sampled(rd_data_o), exp_data_q);
      errors++;
    end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------

  // Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[31]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [XLEN-1:0] random_pc();
    logic [31:0] v;
    v = rand_bits(30);
    return {v[29:0], 2'b00};
  endfunction

  task automatic step_expect();
    chk_q      = chk_en;
    exp_we_q   = exp_we;
    exp_addr_q = exp_addr;
    exp_data_q = exp_data;
  endtask

  task automatic issue(input logic valid, input logic [31:0] instr, input logic [XLEN-1:0] pc);
    logic [XLEN-1:0] res;
    logic            we;
    @(negedge clk);
    step_expect();
    instr_valid_i = valid;
    instr_i       = instr;
    pc_i          = pc;
    res = '0;
    if (valid) begin
      res = expected_result(instr, pc, ref_regs[instr[19:15]], ref_regs[instr[24:20]]);
    end
    we  = valid && writes_register(instr);
    // The write lands on the next edge, in time for the next instruction.
    if (we) begin
      ref_regs[instr[11:7]] = res;
    end
    chk_en    = 1'b1;
    exp_we    = we;
    exp_addr  = instr[11:7];
    exp_data  = res;
    issued++;
  endtask

  task automatic drain(input string name);
    int waited;
    issue(1'b0, '0, '0);
    waited = 0;
    while (seen != issued && waited < 20) begin
      @(negedge clk);
      step_expect();
      chk_en = 1'b0;
      waited++;
    end
    if (seen != issued) begin
      $display("Timeout: the results of test %s stopped arriving", name);
      $display("TEST FAILED");
      $finish;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic load_registers();
    for (int r = 1; r < NUM_REGS; r++) begin
      issue(1'b1, u_type_word(20'(rand_bits(20)), 5'(r), OPC_LUI), '0);
    end
    for (int r = 1; r < NUM_REGS; r++) begin
      issue(1'b1, i_type_word(12'(rand_bits(12)), 5'(r), 3'b000, 5'(r), OPC_OP_IMM), '0);
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------

  task automatic reset_and_idle();
    int         e0;
    logic [4:0] rd;
    e0 = errors;
    assert (rd_we_o == 1'b0 && rd_addr_o == '0 && rd_data_o == '0)
      else begin
        $display("ERROR at time %0t: outputs not cleared after reset", $time);
        errors++;
      end
    // Legal writes to nonzero registers, presented without the strobe.
    for (int i = 0; i < 6; i++) begin
      rd = 5'd1 + 5'(rand_bits(4));
      if (i % 2 == 0) begin
        issue(1'b0, u_type_word(20'(rand_bits(20)), rd, OPC_LUI), random_pc());
      end else begin
        issue(1'b0, i_type_word(12'(rand_bits(12)), 5'(rand_bits(5)), 3'b000, rd, OPC_OP_IMM),
              random_pc());
      end
    end
    drain("reset_and_idle");
    finish_test("reset_and_idle", e0);
  endtask

  task automatic reg_reg_ops();
    int         e0;
    logic [2:0] f3;
    logic       alt;
    e0 = errors;
    load_registers();
    for (int op = 0; op < 10; op++) begin
      // Ops 0 to 7 follow funct3, 8 and 9 are SUB and SRA.
      f3  = (op < 8) ? 3'(op) : ((op == 8) ? 3'b000 : 3'b101);
      alt = (op >= 8);
      for (int n = 0; n < 8; n++) begin
        issue(1'b1, r_type_word(alt ? F7_ALT : F7_BASE, 5'(rand_bits(5)), 5'(rand_bits(5)),
                                f3, 5'(rand_bits(5))), random_pc());
      end
    end
    // A negative register against a small positive one.
    issue(1'b1, u_type_word(20'h80000, 5'd20, OPC_LUI), '0);
    issue(1'b1, i_type_word(12'd9, 5'd0, 3'b000, 5'd21, OPC_OP_IMM), '0);
    issue(1'b0, '0, '0);
    issue(1'b1, r_type_word(F7_ALT, 5'd21, 5'd20, 3'b101, 5'd22), '0);
    issue(1'b1, r_type_word(F7_BASE, 5'd21, 5'd20, 3'b010, 5'd23), '0);
    issue(1'b1, r_type_word(F7_BASE, 5'd21, 5'd20, 3'b011, 5'd24), '0);
    drain("reg_reg_ops");
    finish_test("reg_reg_ops", e0);
  endtask

  task automatic reg_imm_ops();
    int          e0;
    logic [2:0]  f3;
    logic [11:0] imm;
    e0 = errors;
    for (int n = 0; n < 72; n++) begin
      f3  = 3'(rand_bits(3));
      imm = 12'(rand_bits(12));
      if (f3 == 3'b001) begin
        imm[11:5] = 7'h00;
      end else if (f3 == 3'b101) begin
        imm[11:5] = rand_bits(1) ? 7'h20 : 7'h00;
      end
      issue(1'b1, i_type_word(imm, 5'(rand_bits(5)), f3, 5'(rand_bits(5)), OPC_OP_IMM),
            random_pc());
    end
    // Each link adds to what the one before it wrote into x26.
    for (int n = 0; n < 6; n++) begin
      issue(1'b1, i_type_word(12'(rand_bits(12)), 5'd26, 3'b000, 5'd26, OPC_OP_IMM), '0);
    end
    drain("reg_imm_ops");
    finish_test("reg_imm_ops", e0);
  endtask

  task automatic upper_and_jump();
    int e0;
    e0 = errors;
    for (int n = 0; n < 8; n++) begin
      issue(1'b1, u_type_word(20'(rand_bits(20)), 5'(rand_bits(5)), OPC_LUI), random_pc());
      issue(1'b1, u_type_word(20'(rand_bits(20)), 5'(rand_bits(5)), OPC_AUIPC), random_pc());
      issue(1'b1, j_type_word(21'(rand_bits(21)), 5'(rand_bits(5))), random_pc());
      issue(1'b1, i_type_word(12'(rand_bits(12)), 5'(rand_bits(5)), 3'b000, 5'(rand_bits(5)),
                              OPC_JALR), random_pc());
    end
    drain("upper_and_jump");
    finish_test("upper_and_jump", e0);
  endtask

  task automatic x0_and_unsupported();
    int          e0;
    logic [31:0] v;
    logic [6:0]  opc;
    e0 = errors;
    issue(1'b1, i_type_word(12'd5, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), '0);
    issue(1'b1, u_type_word(20'(rand_bits(20)), 5'd0, OPC_LUI), '0);
    issue(1'b0, '0, '0);
    issue(1'b1, r_type_word(F7_BASE, 5'd0, 5'd0, 3'b110, 5'd12), '0);
    // Loads, stores, branches and system instructions are outside this path.
    for (int n = 0; n < 8; n++) begin
      case (rand_bits(2))
        2'd0:    opc = 7'b0000011;
        2'd1:    opc = 7'b0100011;
        2'd2:    opc = 7'b1100011;
        default: opc = 7'b1110011;
      endcase
      v = rand_bits(25);
      issue(1'b1, {v[24:0], opc}, random_pc());
    end
    issue(1'b0, '0, '0);
    for (int r = 1; r < NUM_REGS; r++) begin
      issue(1'b1, r_type_word(F7_BASE, 5'd0, 5'(r), 3'b000, 5'(r)), '0);
    end
    drain("x0_and_unsupported");
    finish_test("x0_and_unsupported", e0);
  endtask

  initial begin
    lfsr_state    = 32'h64ba;
    errors        = 0;
    issued        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    reset_i       = 1'b1;
    // Reset has to hold off the write of this LUI.
    instr_valid_i = 1'b1;
    instr_i       = u_type_word(20'hfffff, 5'd1, OPC_LUI);
    pc_i          = '0;
    chk_en        = 1'b0;
    exp_we        = 1'b0;
    exp_addr      = '0;
    exp_data      = '0;
    step_expect();
    for (int i = 0; i < NUM_REGS; i++) begin
      ref_regs[i] = '0;
    end
    for (int c = 0; c < 5; c++) begin
      @(posedge clk);
    end
    @(negedge clk);
    reset_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;

    reset_and_idle();
    reg_reg_ops();
    reg_imm_ops();
    upper_and_jump();
    x0_and_unsupported();

    $display("tests run %0d, failed %0d, results checked %0d, errors %0d",
             tests_run, tests_failed, seen, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verification
verilog/core_pkg.sv
verilog/isa_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/fu.sv
verilog/rv_writeback.sv
verilog/rv_exec_top.sv
verification/tb_rv_exec.sv

/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

  // ------------------------------
  // Datapath
  // ------------------------------

  // Width of data words, addresses and the program counter.
  localparam int unsigned XLEN = 32;

  // Size of one instruction in bytes. The link value of a jump is pc + PC_STEP.
  localparam int unsigned PC_STEP = 4;

  // ------------------------------
  // Register file
  // ------------------------------

  // Width of a register index as carried in the rs1, rs2 and rd fields.
  localparam int unsigned REG_ADDR_W = 5;

  // Number of architectural integer registers, x0 included.
  localparam int unsigned NUM_REGS = 32;

endpackage

`default_nettype wire

/* verilog/fu.sv */
`default_nettype none

module fu
  import core_pkg::*;
  import isa_pkg::*;
(
  input  logic            reset_i,
  input  inst_type_t      inst_type_i,
  input  alu_op_t         alu_op_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] rdata1_i,
  input  logic [XLEN-1:0] rdata2_i,
  output logic [XLEN-1:0] alu_result_o
);

  logic            idle;
  logic [XLEN-1:0] operand1;
  logic [XLEN-1:0] operand2;
  logic [4:0]      shamt;
  logic [XLEN-1:0] upper_imm;

  assign idle = reset_i || (inst_type_i == INST_NOP) || (alu_op_i == ALU_OP_NOP);

  // ------------------------------
  // Operand selection
  // ------------------------------

  always_comb begin
    case (inst_type_i)
      INST_RR, INST_RI:             operand1 = rdata1_i;
      INST_AUIPC, INST_JAL, INST_JALR: operand1 = pc_i;
      default:                      operand1 = '0;
    endcase
  end

  always_comb begin
    case (inst_type_i)
      INST_RR:                     operand2 = rdata2_i;
      INST_RI, INST_LUI, INST_AUIPC: operand2 = imm_i;
      default:                     operand2 = '0;
    endcase
  end

  assign shamt     = operand2[4:0];
  assign upper_imm = {operand2[19:0], 12'b0};

  // ------------------------------
  // ALU
  // ------------------------------

  always_comb begin
    if (idle) begin
      alu_result_o = '0;
    end else begin
      case (alu_op_i)
        ALU_OP_ADD:   alu_result_o = operand1 + operand2;
        ALU_OP_SUB:   alu_result_o = operand1 - operand2;
        ALU_OP_XOR:   alu_result_o = operand1 ^ operand2;
        ALU_OP_OR:    alu_result_o = operand1 | operand2;
        ALU_OP_AND:   alu_result_o = operand1 & operand2;
        ALU_OP_SLL:   alu_result_o = operand1 << shamt;
        ALU_OP_SRL:   alu_result_o = operand1 >> shamt;
        ALU_OP_SRA:   alu_result_o = $unsigned($signed(operand1) >>> shamt);
        ALU_OP_SLT:   alu_result_o = {{(XLEN-1){1'b0}}, $signed(operand1) < $signed(operand2)};
        ALU_OP_SLTU:  alu_result_o = {{(XLEN-1){1'b0}}, operand1 < operand2};
        // LUI sees a zero operand1, so both forms share the same adder.
        ALU_OP_LUI,
        ALU_OP_AUIPC: alu_result_o = operand1 + upper_imm;
        ALU_OP_JUMP:  alu_result_o = operand1 + XLEN'(PC_STEP);
        default:      alu_result_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  // ------------------------------
  // Decoded instruction classes
  // ------------------------------

  // Class of an instruction, which selects the operands in fu.
  typedef enum logic [2:0] {
    INST_NOP,
    INST_RR,
    INST_RI,
    INST_LUI,
    INST_AUIPC,
    INST_JAL,
    INST_JALR
  } inst_type_t;

  // Operation performed by the ALU.
  typedef enum logic [3:0] {
    ALU_OP_NOP,
    ALU_OP_ADD,
    ALU_OP_SUB,
    ALU_OP_XOR,
    ALU_OP_OR,
    ALU_OP_AND,
    ALU_OP_SLL,
    ALU_OP_SRL,
    ALU_OP_SRA,
    ALU_OP_SLT,
    ALU_OP_SLTU,
    ALU_OP_LUI,
    ALU_OP_AUIPC,
    ALU_OP_JUMP
  } alu_op_t;

  // ------------------------------
  // RV32I encodings
  // ------------------------------

  // Major opcodes, instruction bits 6:0.
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // funct3 values, instruction bits 14:12.
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_JALR    = 3'b000;

  // funct7 values. The alternate one selects SUB and SRA.
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

/* verilog/rv_decoder.sv */
`default_nettype none

module rv_decoder
  import core_pkg::*;
  import isa_pkg::*;
(
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_i,
  output inst_type_t            inst_type_o,
  output alu_op_t               alu_op_o,
  output logic [REG_ADDR_W-1:0] rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rs2_addr_o,
  output logic [REG_ADDR_W-1:0] rd_addr_o,
  output logic [XLEN-1:0]       imm_o
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_j_type;
  logic            is_rr;
  logic            alt_allowed;
  logic            rr_legal;
  logic            ri_legal;
  alu_op_t         f3_op;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Register fields sit at fixed positions in every format.
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];
  assign rd_addr_o  = instr_i[11:7];

  // ------------------------------
  // Immediates
  // ------------------------------

  assign imm_i_type = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  // The U field stays right-aligned; fu moves it into the upper bits.
  assign imm_u_type = {{(XLEN-20){1'b0}}, instr_i[31:12]};
  assign imm_j_type = {{(XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  // ------------------------------
  // Operation decode
  // ------------------------------

  assign is_rr = (opcode == OPC_OP);

  // Only SUB and SRA use the alternate funct7, and SUB has no immediate form.
  assign alt_allowed = (funct3 == F3_SRL_SRA) || (is_rr && funct3 == F3_ADD_SUB);

  assign rr_legal = (funct7 == F7_BASE) || (funct7 == F7_ALT && alt_allowed);

  // For immediate shifts funct7 is a real field, otherwise it is immediate data.
  assign ri_legal = (funct3 == F3_SLL || funct3 == F3_SRL_SRA) ? rr_legal : 1'b1;

  always_comb begin
    case (funct3)
      F3_ADD_SUB: f3_op = (is_rr && funct7 == F7_ALT) ? ALU_OP_SUB : ALU_OP_ADD;
      F3_SLL:     f3_op = ALU_OP_SLL;
      F3_SLT:     f3_op = ALU_OP_SLT;
      F3_SLTU:    f3_op = ALU_OP_SLTU;
      F3_XOR:     f3_op = ALU_OP_XOR;
      F3_SRL_SRA: f3_op = (funct7 == F7_ALT) ? ALU_OP_SRA : ALU_OP_SRL;
      F3_OR:      f3_op = ALU_OP_OR;
      F3_AND:     f3_op = ALU_OP_AND;
      default:    f3_op = ALU_OP_NOP;
    endcase
  end

  always_comb begin
    inst_type_o = INST_NOP;
    alu_op_o    = ALU_OP_NOP;
    imm_o       = '0;
    if (instr_valid_i) begin
      case (opcode)
        OPC_OP: begin
          if (rr_legal) begin
            inst_type_o = INST_RR;
            alu_op_o    = f3_op;
          end
        end
        OPC_OP_IMM: begin
          if (ri_legal) begin
            inst_type_o = INST_RI;
            alu_op_o    = f3_op;
            imm_o       = imm_i_type;
          end
        end
        OPC_LUI: begin
          inst_type_o = INST_LUI;
          alu_op_o    = ALU_OP_LUI;
          imm_o       = imm_u_type;
        end
        OPC_AUIPC: begin
          inst_type_o = INST_AUIPC;
          alu_op_o    = ALU_OP_AUIPC;
          imm_o       = imm_u_type;
        end
        OPC_JAL: begin
          inst_type_o = INST_JAL;
          alu_op_o    = ALU_OP_JUMP;
          imm_o       = imm_j_type;
        end
        OPC_JALR: begin
          if (funct3 == F3_JALR) begin
            inst_type_o = INST_JALR;
            alu_op_o    = ALU_OP_JUMP;
            imm_o       = imm_i_type;
          end
        end
        // Anything else falls through as a no-operation.
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/rv_exec_top.sv */
`default_nettype none

module rv_exec_top
  import core_pkg::*;
  import isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_i,
  input  logic [XLEN-1:0]       pc_i,
  output logic                  rd_we_o,
  output logic [REG_ADDR_W-1:0] rd_addr_o,
  output logic [XLEN-1:0]       rd_data_o
);

  inst_type_t            inst_type;
  alu_op_t               alu_op;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       imm;
  logic [XLEN-1:0]       rdata1;
  logic [XLEN-1:0]       rdata2;
  logic [XLEN-1:0]       alu_result;
  logic                  rf_we;

  rv_decoder u_decoder (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .inst_type_o   (inst_type),
    .alu_op_o      (alu_op),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rd_addr_o     (rd_addr),
    .imm_o         (imm)
  );

  // The write port takes the result that write-back is about to register,
  // so the write lands on the same edge that presents it at the outputs.
  // The register file itself drops writes to x0.
  assign rf_we = (inst_type != INST_NOP);

  rv_regfile u_regfile (
    .clk        (clk),
    .reset_i    (reset_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rdata1_o   (rdata1),
    .rdata2_o   (rdata2),
    .we_i       (rf_we),
    .waddr_i    (rd_addr),
    .wdata_i    (alu_result)
  );

  fu u_fu (
    .reset_i      (reset_i),
    .inst_type_i  (inst_type),
    .alu_op_i     (alu_op),
    .pc_i         (pc_i),
    .imm_i        (imm),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .alu_result_o (alu_result)
  );

  rv_writeback u_writeback (
    .clk          (clk),
    .reset_i      (reset_i),
    .inst_type_i  (inst_type),
    .rd_addr_i    (rd_addr),
    .alu_result_i (alu_result),
    .rd_we_o      (rd_we_o),
    .rd_addr_o    (rd_addr_o),
    .rd_data_o    (rd_data_o)
  );

endmodule

`default_nettype wire

/* verilog/rv_regfile.sv */
`default_nettype none

module rv_regfile
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic [REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [REG_ADDR_W-1:0] rs2_addr_i,
  output logic [XLEN-1:0]       rdata1_o,
  output logic [XLEN-1:0]       rdata2_o,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i
);

  logic [XLEN-1:0] regs [NUM_REGS];

  // Reads are combinational, so a value written on an edge is seen
  // by the instruction decoded in the following cycle.
  assign rdata1_o = regs[rs1_addr_i];
  assign rdata2_o = regs[rs2_addr_i];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 is hardwired to zero on both read ports, whatever was written before.
  a_x0_reads_zero : assert property (
    @(posedge clk) disable iff (reset_i)
      (rs1_addr_i != '0 || rdata1_o == '0) && (rs2_addr_i != '0 || rdata2_o == '0)
  ) else $error("x0 read returned a nonzero value");

endmodule

`default_nettype wire

/* verilog/rv_writeback.sv */
`default_nettype none

module rv_writeback
  import core_pkg::*;
  import isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_i,
  input  inst_type_t            inst_type_i,
  input  logic [REG_ADDR_W-1:0] rd_addr_i,
  input  logic [XLEN-1:0]       alu_result_i,
  output logic                  rd_we_o,
  output logic [REG_ADDR_W-1:0] rd_addr_o,
  output logic [XLEN-1:0]       rd_data_o
);

  logic write_ok;

  // No-operations and writes to x0 leave the register file alone.
  assign write_ok = (inst_type_i != INST_NOP) && (rd_addr_i != '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rd_we_o   <= 1'b0;
      rd_addr_o <= '0;
      rd_data_o <= '0;
    end else begin
      rd_we_o   <= write_ok;
      rd_addr_o <= rd_addr_i;
      rd_data_o <= alu_result_i;
    end
  end

  a_no_x0_write : assert property (
    @(posedge clk) disable iff (reset_i)
      !(rd_we_o && rd_addr_o == '0)
  ) else $error("write-back enabled with destination x0");

endmodule

`default_nettype wire
